// ==== design/osf_latency_stamp.sv ====
`include "osf_macros.svh"

module osf_latency_stamp #(
  parameter int LAT_W = `OSF_LAT_W
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      rd,
  osf_stream_if.snk in,
  osf_stream_if.src out
);
  import osf_pkg::*;

  osf_lat_st_e      state;
  osf_lat_st_e      state_nxt;
  logic [LAT_W-1:0] lat_cnt;
  logic             sot;
  logic             eot;
  logic             is_rqe;
  logic             is_stat;
  logic             cnt_en;
  logic             cnt_clr;
  logic             stamp_sel;
  tlv_word_u        stamped;

  assign sot     = (in.tuser == `OSF_TUSER_SOT);
  assign eot     = (in.tuser == `OSF_TUSER_EOT);
  assign is_rqe  = (in.tdata.w0.tlv_type == RQE);
  assign is_stat = (in.tdata.w0.tlv_type == STAT);

  always_comb
  begin
    state_nxt = state;
    cnt_en    = 1'b0;
    cnt_clr   = 1'b0;
    stamp_sel = 1'b0;

    case (state)
      LAT_IDLE:
      begin
        cnt_clr = 1'b1;
        if (rd && sot && is_rqe)
        begin
          cnt_clr   = 1'b0;
          cnt_en    = 1'b1;  // zero in the RQE pop cycle, counting after it
          state_nxt = LAT_WAIT;
        end
      end

      LAT_WAIT:
      begin
        cnt_en = 1'b1;
        if (rd && sot && is_stat)
          state_nxt = LAT_STAT;
      end

      LAT_STAT:
      begin
        cnt_en = 1'b1;
        if (rd)
        begin
          if (eot)
          begin
            // STAT ended before word 2, nothing to stamp
            cnt_en    = 1'b0;
            cnt_clr   = 1'b1;
            state_nxt = LAT_IDLE;
          end
          else
            state_nxt = LAT_INSERT;  // word 1 popped
        end
        // a stall keeps us here so the stamp is not lost
      end

      LAT_INSERT:
      begin
        stamp_sel = 1'b1;
        if (rd)
        begin
          cnt_clr   = 1'b1;
          state_nxt = LAT_IDLE;
        end
        else
          cnt_en = 1'b1;  // stalls add to the latency
      end

      default: state_nxt = LAT_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= LAT_IDLE;
      lat_cnt <= '0;
    end
    else
    begin
      state <= state_nxt;
      if (cnt_clr)
        lat_cnt <= '0;
      else if (cnt_en)
        lat_cnt <= lat_cnt + 1'b1;
    end
  end

  always_comb
  begin
    stamped             = in.tdata;
    stamped.sw2.latency = lat_t'(lat_cnt + 1'b1);
  end

  assign out.tvalid = in.tvalid;
  assign out.tlast  = in.tlast;
  assign out.tid    = in.tid;
  assign out.tstrb  = in.tstrb;
  assign out.tuser  = in.tuser;
  assign out.tdata  = stamp_sel ? stamped : in.tdata;

  a_insert_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (state == LAT_INSERT) && (state_nxt != LAT_INSERT) |-> rd && in.tvalid && !sot)
    else $error("stamper left INSERT without popping STAT word 2");

  a_idle_cnt_zero: assert property (@(posedge clk) disable iff (!rst_n)
    (state == LAT_IDLE) |-> (lat_cnt == '0))
    else $error("latency counter not zero in IDLE");

endmodule

// ==== design/osf_macros.svh ====
`ifndef OSF_MACROS_SVH
`define OSF_MACROS_SVH

// stream word width
`define OSF_DATA_W 64

// latency count width, also the width of the stats latency field
`define OSF_LAT_W 24

// word FIFO entries, power of two
`define OSF_FIFO_DEPTH 16

// tuser codes
`define OSF_TUSER_SOT 8'd1
`define OSF_TUSER_EOT 8'd2

`endif

// ==== design/osf_out_stage.sv ====
`include "osf_macros.svh"

module osf_out_stage (
  input  logic               clk,
  input  logic               rst_n,
  osf_stream_if.snk          in,
  output logic               pop,
  input  logic               out_ready,
  output logic               out_valid,
  output osf_pkg::tlv_word_u out_word,
  output logic [7:0]         out_tuser,
  output logic               out_tlast,
  output logic [3:0]         out_tid,
  output logic [7:0]         out_tstrb,
  output logic [15:0]        frmd_cnt
);
  import osf_pkg::*;

  logic frmd_sot;

  // register is free when empty or being drained this cycle
  assign pop = in.tvalid && (!out_valid || out_ready);

  assign frmd_sot = (in.tuser == `OSF_TUSER_SOT) && osf_is_framed(in.tdata.w0.tlv_type);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      out_valid <= 1'b0;
      frmd_cnt  <= '0;
    end
    else
    begin
      if (pop)
        out_valid <= 1'b1;
      else if (out_ready)
        out_valid <= 1'b0;

      if (pop && frmd_sot)
        frmd_cnt <= frmd_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (pop)
    begin
      out_word  <= in.tdata;
      out_tuser <= in.tuser;
      out_tlast <= in.tlast;
      out_tid   <= in.tid;
      out_tstrb <= in.tstrb;
    end
  end

  // held word must not change under back-pressure
  a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_word))
    else $error("output word changed while stalled");

endmodule

// ==== design/osf_pkg.sv ====
`include "osf_macros.svh"

package osf_pkg;

  typedef enum logic [7:0] {
    RQE               = 8'h00,
    FRMD_USER_NULL    = 8'h01,
    FRMD_USER_PI16    = 8'h02,
    FRMD_USER_PI64    = 8'h03,
    FRMD_USER_VM      = 8'h04,
    FRMD_INT_APP      = 8'h05,
    FRMD_INT_SIP      = 8'h06,
    FRMD_INT_LIP      = 8'h07,
    FRMD_INT_VM       = 8'h08,
    FRMD_INT_VM_SHORT = 8'h09,
    DATA              = 8'h0a,  // filler
    STAT              = 8'h0b
  } tlv_type_e;

  typedef logic [`OSF_LAT_W-1:0] lat_t;

  // word 0 of every TLV
  typedef struct packed {
    logic [`OSF_DATA_W-25:0] rsvd;
    logic [15:0]             tlv_len;
    tlv_type_e               tlv_type;
  } tlv_word_0_t;

  // word 2 of a STAT TLV
  typedef struct packed {
    logic [`OSF_DATA_W-`OSF_LAT_W-10:0] rsvd1;
    logic                               frame_error;
    logic [7:0]                         rsvd0;
    lat_t                               latency;
  } tlv_stats_word2_t;

  typedef union packed {
    tlv_word_0_t      w0;
    tlv_stats_word2_t sw2;
  } tlv_word_u;

  typedef enum logic [1:0] {
    LAT_IDLE,
    LAT_WAIT,    // RQE seen, waiting for STAT
    LAT_STAT,    // STAT word 0 popped
    LAT_INSERT   // head is STAT word 2
  } osf_lat_st_e;

  function automatic logic osf_is_framed(tlv_type_e t);
    logic framed;
    case (t)
      FRMD_USER_NULL,
      FRMD_USER_PI16,
      FRMD_USER_PI64,
      FRMD_USER_VM,
      FRMD_INT_APP,
      FRMD_INT_SIP,
      FRMD_INT_LIP,
      FRMD_INT_VM,
      FRMD_INT_VM_SHORT: framed = 1'b1;
      default:           framed = 1'b0;
    endcase
    return framed;
  endfunction

endpackage

// ==== design/osf_stream_if.sv ====
interface osf_stream_if;
  import osf_pkg::*;

  logic       tvalid;
  logic       tlast;
  logic [3:0] tid;
  logic [7:0] tstrb;
  logic [7:0] tuser;  // 1 = start word, 2 = end word
  tlv_word_u  tdata;

  modport src (
    output tvalid,
    output tlast,
    output tid,
    output tstrb,
    output tuser,
    output tdata
  );

  modport snk (
    input tvalid,
    input tlast,
    input tid,
    input tstrb,
    input tuser,
    input tdata
  );

endinterface

// ==== design/osf_top.sv ====
`include "osf_macros.svh"

module osf_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               in_push,
  input  osf_pkg::tlv_word_u in_word,
  input  logic [7:0]         in_tuser,
  input  logic               in_tlast,
  input  logic [3:0]         in_tid,
  input  logic [7:0]         in_tstrb,
  output logic               in_full,
  input  logic               out_ready,
  output logic               out_valid,
  output osf_pkg::tlv_word_u out_word,
  output logic [7:0]         out_tuser,
  output logic               out_tlast,
  output logic [3:0]         out_tid,
  output logic [7:0]         out_tstrb,
  output logic [15:0]        frmd_cnt
);

  logic mstr_rd;  // pop strobe to FIFO and stamper

  osf_stream_if fifo_if ();
  osf_stream_if stamp_if ();

  osf_word_fifo fifo_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_push  (in_push),
    .in_word  (in_word),
    .in_tuser (in_tuser),
    .in_tlast (in_tlast),
    .in_tid   (in_tid),
    .in_tstrb (in_tstrb),
    .pop      (mstr_rd),
    .full     (in_full),
    .head     (fifo_if.src)
  );

  osf_latency_stamp #(
    .LAT_W (`OSF_LAT_W)
  ) stamp_i (
    .clk   (clk),
    .rst_n (rst_n),
    .rd    (mstr_rd),
    .in    (fifo_if.snk),
    .out   (stamp_if.src)
  );

  osf_out_stage out_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in        (stamp_if.snk),
    .pop       (mstr_rd),
    .out_ready (out_ready),
    .out_valid (out_valid),
    .out_word  (out_word),
    .out_tuser (out_tuser),
    .out_tlast (out_tlast),
    .out_tid   (out_tid),
    .out_tstrb (out_tstrb),
    .frmd_cnt  (frmd_cnt)
  );

endmodule

// ==== design/osf_word_fifo.sv ====
`include "osf_macros.svh"

module osf_word_fifo (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              in_push,
  input  osf_pkg::tlv_word_u in_word,
  input  logic [7:0]        in_tuser,
  input  logic              in_tlast,
  input  logic [3:0]        in_tid,
  input  logic [7:0]        in_tstrb,
  input  logic              pop,
  output logic              full,
  osf_stream_if.src         head
);
  import osf_pkg::*;

  localparam int DEPTH = `OSF_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);

  tlv_word_u  mem_data  [DEPTH];
  logic [7:0] mem_tuser [DEPTH];
  logic       mem_tlast [DEPTH];
  logic [3:0] mem_tid   [DEPTH];
  logic [7:0] mem_tstrb [DEPTH];

  logic [AW:0] wr_ptr;  // extra bit tells full from empty
  logic [AW:0] rd_ptr;
  logic        empty;
  logic        wr_en;
  logic        rd_en;

  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign empty = (wr_ptr == rd_ptr);
  assign wr_en = in_push && !full;
  assign rd_en = pop && !empty;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (wr_en)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd_en)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      mem_data[wr_ptr[AW-1:0]]  <= in_word;
      mem_tuser[wr_ptr[AW-1:0]] <= in_tuser;
      mem_tlast[wr_ptr[AW-1:0]] <= in_tlast;
      mem_tid[wr_ptr[AW-1:0]]   <= in_tid;
      mem_tstrb[wr_ptr[AW-1:0]] <= in_tstrb;
    end
  end

  // head word is visible without a read latency
  assign head.tvalid = !empty;
  assign head.tdata  = mem_data[rd_ptr[AW-1:0]];
  assign head.tuser  = mem_tuser[rd_ptr[AW-1:0]];
  assign head.tlast  = mem_tlast[rd_ptr[AW-1:0]];
  assign head.tid    = mem_tid[rd_ptr[AW-1:0]];
  assign head.tstrb  = mem_tstrb[rd_ptr[AW-1:0]];

  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    !(in_push && full))
    else $error("push while FIFO full");

  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    !(pop && empty))
    else $error("pop while FIFO empty");

endmodule

// ==== osf.f ====
+incdir+design
design/osf_pkg.sv
design/osf_stream_if.sv
design/osf_word_fifo.sv
design/osf_latency_stamp.sv
design/osf_out_stage.sv
design/osf_top.sv
verif/osf_tb.sv

// ==== run_osf.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  -f osf.f \
  --top-module osf_tb \
  -o osf_sim

./obj_dir/osf_sim | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
  echo "run_osf: testbench reported errors, see sim.log"
  exit 1
fi

echo "run_osf: finished without reported errors"

// ==== verif/osf_tb.sv ====
`include "osf_macros.svh"

module osf_tb;
  import osf_pkg::*;

  logic        clk;
  logic        rst_n;
  logic        in_push;
  tlv_word_u   in_word;
  logic [7:0]  in_tuser;
  logic        in_tlast;
  logic [3:0]  in_tid;
  logic [7:0]  in_tstrb;
  logic        in_full;
  logic        out_ready;
  logic        out_valid;
  tlv_word_u   out_word;
  logic [7:0]  out_tuser;
  logic        out_tlast;
  logic [3:0]  out_tid;
  logic [7:0]  out_tstrb;
  logic [15:0] frmd_cnt;

  int seed;
  int n_words;
  int tmo_limit;
  int frm_sent;
  int push_idx;
  int rate;  // push attempts allowed out of 4

  tlv_word_u  gen_word [$];
  logic [7:0] gen_tuser [$];
  logic       gen_tlast [$];
  logic [3:0] gen_tid [$];
  logic [7:0] gen_tstrb [$];

  tlv_type_e framed_list [9] = '{FRMD_USER_NULL, FRMD_USER_PI16, FRMD_USER_PI64,
                                  FRMD_USER_VM, FRMD_INT_APP, FRMD_INT_SIP,
                                  FRMD_INT_LIP, FRMD_INT_VM, FRMD_INT_VM_SHORT};

  int        cyc;
  int        rx_idx;
  int        push_cnt;   // words accepted by the FIFO so far
  int        drain_cnt;
  int        chk_errs;
  int        other_errs;
  logic      held;
  tlv_word_u held_word;
  logic      rqe_open;   // model: RQE seen, no stamp yet
  int        rqe_cyc;
  logic      stamp_tlv;
  int        widx;

  always #2 clk = ~clk;

  osf_top dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_push   (in_push),
    .in_word   (in_word),
    .in_tuser  (in_tuser),
    .in_tlast  (in_tlast),
    .in_tid    (in_tid),
    .in_tstrb  (in_tstrb),
    .in_full   (in_full),
    .out_ready (out_ready),
    .out_valid (out_valid),
    .out_word  (out_word),
    .out_tuser (out_tuser),
    .out_tlast (out_tlast),
    .out_tid   (out_tid),
    .out_tstrb (out_tstrb),
    .frmd_cnt  (frmd_cnt)
  );

  task automatic check_word(input tlv_word_u got, input tlv_word_u exp, input string msg);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, got, exp);
      chk_errs++;
    end
  endtask

  task automatic check_side(input logic [7:0] got_tuser, input logic got_tlast,
                            input logic [3:0] got_tid, input logic [7:0] got_tstrb,
                            input logic [7:0] exp_tuser, input logic exp_tlast,
                            input logic [3:0] exp_tid, input logic [7:0] exp_tstrb);
    if ({got_tuser, got_tlast, got_tid, got_tstrb} !== {exp_tuser, exp_tlast, exp_tid, exp_tstrb})
    begin
      $display("CHECK FAILED at %0t: side signals got %h/%b/%h/%h expected %h/%b/%h/%h",
               $time, got_tuser, got_tlast, got_tid, got_tstrb,
               exp_tuser, exp_tlast, exp_tid, exp_tstrb);
      chk_errs++;
    end
  endtask

  task automatic check_count(input logic [15:0] got, input logic [15:0] exp, input string msg);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, msg, got, exp);
      chk_errs++;
    end
  endtask

  task automatic add_tlv(input tlv_type_e t, input int len);
    int         i;
    tlv_word_u  w;
    logic [3:0] id;
    id = 4'($random(seed));
    for (i = 0; i < len; i++)
    begin
      w = {$random(seed), $random(seed)};
      if (i == 0)
      begin
        w.w0.tlv_type = t;
        w.w0.tlv_len  = 16'(len);
        gen_tuser.push_back(`OSF_TUSER_SOT);
      end
      else if (i == len - 1)
        gen_tuser.push_back(`OSF_TUSER_EOT);
      else
        gen_tuser.push_back(8'd0);
      gen_word.push_back(w);
      gen_tlast.push_back(i == len - 1);
      gen_tid.push_back(id);
      gen_tstrb.push_back((i == len - 1) ? (8'($random(seed)) | 8'h01) : 8'hff);
    end
  endtask

  task automatic build_stream();
    int   k;
    int   pick;
    int   len;
    int   fi;
    logic open;
    open = 1'b0;
    for (k = 0; k < 60; k++)
    begin
      pick = {$random(seed)} % 8;
      len  = 1 + {$random(seed)} % 6;
      if (pick == 0 && !open)
      begin
        add_tlv(RQE, len);
        open = 1'b1;
      end
      else if (pick <= 1)
      begin
        add_tlv(STAT, 3 + {$random(seed)} % 4);  // may come without an RQE
        open = 1'b0;
      end
      else if (pick <= 5)
      begin
        fi = {$random(seed)} % 9;
        add_tlv(framed_list[fi], len);
        frm_sent++;
      end
      else
        add_tlv(DATA, len);
    end
    if (open)
      add_tlv(STAT, 3);
  endtask

  initial
  begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    in_push   = 1'b0;
    in_word   = '0;
    in_tuser  = 8'd0;
    in_tlast  = 1'b0;
    in_tid    = 4'd0;
    in_tstrb  = 8'd0;
    out_ready = 1'b0;
    held      = 1'b0;
    rqe_open  = 1'b0;
    stamp_tlv = 1'b0;
    push_cnt  = 0;
    seed      = 32'hf561;
    push_idx  = 0;
    rate      = 4;
    frm_sent  = 0;
    build_stream();
    n_words   = gen_word.size();
    tmo_limit = 20 * n_words + 200;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    forever
    begin
      @(posedge clk);
      out_ready <= ({$random(seed)} % 3) != 0;
      if (in_push)
      begin
        push_idx++;  // word taken at this edge
        if (push_idx < n_words && gen_tuser[push_idx] == `OSF_TUSER_SOT)
          rate = 1 + {$random(seed)} % 4;
      end
      // no back-to-back push, so a low in_full is still valid next cycle
      if (!in_push && !in_full && push_idx < n_words && ({$random(seed)} % 4) < rate)
      begin
        in_push  <= 1'b1;
        in_word  <= gen_word[push_idx];
        in_tuser <= gen_tuser[push_idx];
        in_tlast <= gen_tlast[push_idx];
        in_tid   <= gen_tid[push_idx];
        in_tstrb <= gen_tstrb[push_idx];
      end
      else
        in_push <= 1'b0;
    end
  end

  always @(posedge clk)
  begin
    tlv_word_u exp_w;
    if (rst_n)
    begin
      cyc = cyc + 1;
      if (cyc == 1)
      begin
        if (out_valid !== 1'b0)
        begin
          $display("CHECK FAILED at %0t: out_valid not low after reset", $time);
          chk_errs++;
        end
        check_count(frmd_cnt, 16'd0, "frmd_cnt after reset");
      end
      if (held)
      begin
        if (out_valid !== 1'b1)
        begin
          $display("held output word was dropped while out_ready was low (time %0t)", $time);
          other_errs++;
        end
        else
          check_word(out_word, held_word, "held word under back-pressure");
      end
      else if (out_valid === 1'b1)
      begin
        if (rx_idx >= n_words)
        begin
          $display("an extra word left the DUT after the last expected one (time %0t)", $time);
          other_errs++;
        end
        else
        begin
          exp_w = gen_word[rx_idx];
          if (gen_tuser[rx_idx] == `OSF_TUSER_SOT)
          begin
            widx = 0;
            if (exp_w.w0.tlv_type == RQE && !rqe_open)
            begin
              rqe_open = 1'b1;
              rqe_cyc  = cyc;
            end
            stamp_tlv = (exp_w.w0.tlv_type == STAT) && rqe_open;
          end
          else
            widx++;
          if (stamp_tlv && widx == 2)
          begin
            exp_w.sw2.latency = lat_t'(cyc - rqe_cyc + 1);  // first-appearance gap plus 1
            rqe_open  = 1'b0;
            stamp_tlv = 1'b0;
          end
          check_word(out_word, exp_w, "output word");
          check_side(out_tuser, out_tlast, out_tid, out_tstrb,
                     gen_tuser[rx_idx], gen_tlast[rx_idx], gen_tid[rx_idx], gen_tstrb[rx_idx]);
          rx_idx++;
        end
        held_word = out_word;
      end
      held = out_valid && !out_ready;

      // words pushed so far minus words already popped
      if (in_full !== ((push_cnt - rx_idx) == `OSF_FIFO_DEPTH))
      begin
        $display("CHECK FAILED at %0t: in_full is %b with %0d words in the FIFO",
                 $time, in_full, push_cnt - rx_idx);
        chk_errs++;
      end
      if (in_push === 1'b1)
        push_cnt++;

      if (rx_idx == n_words)
        drain_cnt++;
      if (drain_cnt == 10)
      begin
        check_count(frmd_cnt, 16'(frm_sent), "frmd_cnt at end of run");
        $display("errors: %0d mismatches, %0d other failures", chk_errs, other_errs);
        if (chk_errs == 0 && other_errs == 0)
          $display("Simulation PASSED");
        else
          $display("Simulation FAILED");
        $finish;
      end
      else if (cyc >= tmo_limit)
      begin
        $display("timeout: only %0d of %0d words left the DUT within %0d cycles",
                 rx_idx, n_words, tmo_limit);
        $display("errors: %0d mismatches, %0d other failures", chk_errs, other_errs + 1);
        $display("Simulation FAILED");
        $finish;
      end
    end
  end

endmodule
